// ==== verilog/ptw_consts.svh ====
/* Sv39 widths and sizes shared by the page-table walker packages, RTL and testbench.
   Include it wherever one of these macros is needed. */

`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// virtual and physical address widths
`define PTW_VLEN 39
`define PTW_PLEN 56

// physical page number and one vpn slice
`define PTW_PPNW 44
`define PTW_VPNW 9

// 4 KiB pages, 8-byte PTEs
`define PTW_PGOFF 12
`define PTW_PTE_BYTES_LOG 3

`define PTW_ASIDW 16

`endif

// ==== verilog/ptw_mem_pkg.sv ====
/* Memory port types of the walker.
   The request carries a PTE address, the response a grant and the read data. */

`include "ptw_consts.svh"

package ptw_mem_pkg;

    // --------------------------------------------------
    // walker to memory
    // --------------------------------------------------
    // valid is held until a cycle with gnt
    typedef struct packed {
        logic                    valid;
        logic [`PTW_PLEN-1:0]    addr;
    } ptw_mem_req_t;

    // --------------------------------------------------
    // memory to walker
    // --------------------------------------------------
    // exactly one rvalid follows each grant, at least a cycle later
    typedef struct packed {
        logic                    gnt;
        logic                    rvalid;
        logic [63:0]             rdata;
    } ptw_mem_rsp_t;

endpackage

// ==== verilog/ptw_pte_pkg.sv ====
/* Page-table entry layout and walker types: levels, states, check verdicts,
   the arbitrated TLB miss and the update sent back to a TLB. */

`include "ptw_consts.svh"

package ptw_pte_pkg;

    // Sv39 PTE, flags in the low byte
    typedef struct packed {
        logic [9:0]              reserved;
        logic [`PTW_PPNW-1:0]    ppn;
        logic [1:0]              rsw;
        logic                    d;
        logic                    a;
        logic                    g;
        logic                    u;
        logic                    x;
        logic                    w;
        logic                    r;
        logic                    v;
    } pte_t;

    // LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } walk_state_e;

    typedef enum logic [1:0] {
        PTE_POINTER,
        PTE_LEAF_OK,
        PTE_FAULT
    } pte_verdict_e;

    // --------------------------------------------------
    // miss into the walker, update out of it
    // --------------------------------------------------
    typedef struct packed {
        logic                    valid;
        logic                    is_instr;
        logic [`PTW_VLEN-1:0]    vaddr;
    } tlb_miss_t;

    typedef struct packed {
        logic                               valid;
        logic                               is_2m;
        logic                               is_1g;
        logic [`PTW_VLEN-`PTW_PGOFF-1:0]    vpn;
        logic [`PTW_ASIDW-1:0]              asid;
        pte_t                               content;
    } tlb_update_t;

endpackage

// ==== verilog/ptw_miss_arbiter.sv ====
/* Selects one TLB miss for the walker, data side first.
   Purely combinational; a miss is only forwarded while the walker is idle. */

`timescale 1ns/1ps

`include "ptw_consts.svh"

module ptw_miss_arbiter (
    input  logic                    itlb_access_i,
    input  logic                    itlb_hit_i,
    input  logic [`PTW_VLEN-1:0]    itlb_vaddr_i,
    input  logic                    dtlb_access_i,
    input  logic                    dtlb_hit_i,
    input  logic [`PTW_VLEN-1:0]    dtlb_vaddr_i,
    input  logic                    enable_translation_i,
    input  logic                    en_ld_st_translation_i,
    input  logic                    busy_i,
    output ptw_pte_pkg::tlb_miss_t  miss_o,
    output logic                    itlb_miss_o,
    output logic                    dtlb_miss_o
);
    import ptw_pte_pkg::*;

    logic i_miss;
    logic d_miss;
    logic d_grant;
    logic i_grant;
    tlb_miss_t sel_miss;

    // each side only counts when its translation is switched on
    assign i_miss = enable_translation_i & itlb_access_i & ~itlb_hit_i;
    assign d_miss = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;

    // data side wins, the fetch miss waits for a later cycle
    assign d_grant = ~busy_i & d_miss;
    assign i_grant = ~busy_i & i_miss & ~d_miss;

    always_comb begin
        sel_miss.valid    = d_grant | i_grant;
        sel_miss.is_instr = i_grant;
        sel_miss.vaddr    = d_miss ? dtlb_vaddr_i : itlb_vaddr_i;
    end

    assign miss_o      = sel_miss;
    assign itlb_miss_o = i_grant;
    assign dtlb_miss_o = d_grant;

endmodule

// ==== verilog/ptw_pte_checker.sv ====
/* Sv39 rule check of one fetched PTE against the current level and access type.
   Answers in the same cycle with pointer, good leaf or fault. */

`timescale 1ns/1ps

`include "ptw_consts.svh"

module ptw_pte_checker (
    input  ptw_pte_pkg::pte_t           pte_i,
    input  ptw_pte_pkg::ptw_lvl_e       lvl_i,
    input  logic                        is_instr_i,
    input  logic                        is_store_i,
    input  logic                        mxr_i,
    output ptw_pte_pkg::pte_verdict_e   verdict_o
);
    import ptw_pte_pkg::*;

    logic perm_ok;
    logic store_ok;
    logic misaligned;

    // --------------------------------------------------
    // leaf permission checks
    // --------------------------------------------------
    always_comb begin
        if (is_instr_i) begin
            // fetch needs execute, accessed bit is managed by software
            perm_ok = pte_i.x & pte_i.a;
        end else begin
            // execute-only pages are readable only with mxr
            perm_ok = pte_i.a & (pte_i.r | (pte_i.x & mxr_i));
        end
    end

    // stores also need write and an already set dirty bit
    assign store_ok = is_instr_i | ~is_store_i | (pte_i.w & pte_i.d);

    // superpages must have the low ppn slices cleared
    always_comb begin
        misaligned = 1'b0;
        if (lvl_i == LVL1) begin
            misaligned = |pte_i.ppn[2*`PTW_VPNW-1:0];
        end else if (lvl_i == LVL2) begin
            misaligned = |pte_i.ppn[`PTW_VPNW-1:0];
        end
    end

    // --------------------------------------------------
    // verdict
    // --------------------------------------------------
    always_comb begin
        verdict_o = PTE_FAULT;
        if (!pte_i.v || (!pte_i.r && pte_i.w)) begin
            // invalid, or the reserved write-only encoding
            verdict_o = PTE_FAULT;
        end else if (!pte_i.r && !pte_i.x) begin
            // pointer, not allowed below the last level
            verdict_o = (lvl_i == LVL3) ? PTE_FAULT : PTE_POINTER;
        end else if (perm_ok && store_ok && !misaligned) begin
            verdict_o = PTE_LEAF_OK;
        end
    end

endmodule

// ==== verilog/ptw_walk_fsm.sv ====
/* Sv39 walk state machine: forms PTE addresses, issues memory reads and
   turns the checker verdict into a TLB update or a page-fault pulse. */

`timescale 1ns/1ps

`include "ptw_consts.svh"

module ptw_walk_fsm (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  ptw_pte_pkg::tlb_miss_t      miss_i,
    output logic                        busy_o,
    input  logic [`PTW_PPNW-1:0]        satp_ppn_i,
    input  logic [`PTW_ASIDW-1:0]       asid_i,
    output ptw_mem_pkg::ptw_mem_req_t   mem_req_o,
    input  ptw_mem_pkg::ptw_mem_rsp_t   mem_rsp_i,
    output ptw_pte_pkg::pte_t           pte_o,
    output ptw_pte_pkg::ptw_lvl_e       lvl_o,
    output logic                        is_instr_o,
    input  ptw_pte_pkg::pte_verdict_e   verdict_i,
    output ptw_pte_pkg::tlb_update_t    itlb_update_o,
    output ptw_pte_pkg::tlb_update_t    dtlb_update_o,
    output logic                        ptw_error_o,
    output logic                        walking_instr_o
);
    import ptw_pte_pkg::*;

    walk_state_e state_q, state_d;
    ptw_lvl_e    lvl_q, lvl_d;
    logic        is_instr_q, is_instr_d;
    logic        global_q, global_d;
    logic        rvalid_q;
    logic [63:0] rdata_q;

    logic [`PTW_PLEN-1:0]  pptr_q, pptr_d;
    logic [`PTW_VLEN-1:0]  vaddr_q, vaddr_d;
    logic [`PTW_ASIDW-1:0] asid_q, asid_d;

    pte_t        pte;
    logic        leaf_ok;
    tlb_update_t update;

    // one 9-bit index of the virtual page number
    function automatic logic [`PTW_VPNW-1:0] vpn_slice(input logic [`PTW_VLEN-1:0] va,
                                                       input int unsigned idx);
        return va[`PTW_PGOFF + idx*`PTW_VPNW +: `PTW_VPNW];
    endfunction

    assign pte = pte_t'(rdata_q);

    assign pte_o      = pte;
    assign lvl_o      = lvl_q;
    assign is_instr_o = is_instr_q;

    assign busy_o          = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;
    assign ptw_error_o     = (state_q == PROPAGATE_ERROR);

    assign mem_req_o.valid = (state_q == WAIT_GRANT);
    assign mem_req_o.addr  = pptr_q;

    // --------------------------------------------------
    // TLB update
    // --------------------------------------------------
    assign leaf_ok = (state_q == PTE_LOOKUP) && rvalid_q && (verdict_i == PTE_LEAF_OK);

    always_comb begin
        update           = '0;
        update.is_2m     = (lvl_q == LVL2);
        update.is_1g     = (lvl_q == LVL1);
        update.vpn       = vaddr_q[`PTW_VLEN-1:`PTW_PGOFF];
        update.asid      = asid_q;
        update.content   = pte;
        // global if any level of the walk was global
        update.content.g = pte.g | global_q;
    end

    always_comb begin
        itlb_update_o       = update;
        dtlb_update_o       = update;
        itlb_update_o.valid = leaf_ok & is_instr_q;
        dtlb_update_o.valid = leaf_ok & ~is_instr_q;
    end

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d    = state_q;
        lvl_d      = lvl_q;
        is_instr_d = is_instr_q;
        global_d   = global_q;
        pptr_d     = pptr_q;
        vaddr_d    = vaddr_q;
        asid_d     = asid_q;

        case (state_q)
            IDLE: begin
                lvl_d      = LVL1;
                global_d   = 1'b0;
                is_instr_d = 1'b0;
                if (miss_i.valid) begin
                    is_instr_d = miss_i.is_instr;
                    vaddr_d    = miss_i.vaddr;
                    asid_d     = asid_i;
                    // root table from satp, indexed by vpn[2]
                    pptr_d     = {satp_ppn_i, vpn_slice(miss_i.vaddr, 2),
                                  {`PTW_PTE_BYTES_LOG{1'b0}}};
                    state_d    = WAIT_GRANT;
                end
            end

            WAIT_GRANT: begin
                if (mem_rsp_i.gnt) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    global_d = global_q | pte.g;
                    case (verdict_i)
                        PTE_POINTER: begin
                            state_d = WAIT_GRANT;
                            if (lvl_q == LVL1) begin
                                lvl_d  = LVL2;
                                pptr_d = {pte.ppn, vpn_slice(vaddr_q, 1),
                                          {`PTW_PTE_BYTES_LOG{1'b0}}};
                            end else begin
                                lvl_d  = LVL3;
                                pptr_d = {pte.ppn, vpn_slice(vaddr_q, 0),
                                          {`PTW_PTE_BYTES_LOG{1'b0}}};
                            end
                        end
                        PTE_LEAF_OK: state_d = IDLE;
                        default:     state_d = PROPAGATE_ERROR;
                    endcase
                end
            end

            // error pulse lasts exactly this cycle
            PROPAGATE_ERROR: state_d = IDLE;

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            lvl_q      <= LVL1;
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            state_q    <= state_d;
            lvl_q      <= lvl_d;
            is_instr_q <= is_instr_d;
            global_q   <= global_d;
            rvalid_q   <= mem_rsp_i.rvalid;
        end
    end

    // walk payload and the registered read data
    always_ff @(posedge clk_i) begin
        pptr_q  <= pptr_d;
        vaddr_q <= vaddr_d;
        asid_q  <= asid_d;
        rdata_q <= mem_rsp_i.rdata;
    end

endmodule

// ==== verilog/ptw_top.sv ====
/* Page-table walker top level serving the ITLB and DTLB over one memory port.
   Connects the miss arbiter, the walk state machine and the PTE checker. */

`timescale 1ns/1ps

`include "ptw_consts.svh"

module ptw_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        itlb_access_i,
    input  logic                        itlb_hit_i,
    input  logic [`PTW_VLEN-1:0]        itlb_vaddr_i,
    input  logic                        dtlb_access_i,
    input  logic                        dtlb_hit_i,
    input  logic [`PTW_VLEN-1:0]        dtlb_vaddr_i,
    input  logic                        enable_translation_i,
    input  logic                        en_ld_st_translation_i,
    input  logic [`PTW_PPNW-1:0]        satp_ppn_i,
    input  logic [`PTW_ASIDW-1:0]       asid_i,
    input  logic                        mxr_i,
    input  logic                        lsu_is_store_i,
    output ptw_mem_pkg::ptw_mem_req_t   mem_req_o,
    input  ptw_mem_pkg::ptw_mem_rsp_t   mem_rsp_i,
    output ptw_pte_pkg::tlb_update_t    itlb_update_o,
    output ptw_pte_pkg::tlb_update_t    dtlb_update_o,
    output logic                        ptw_error_o,
    output logic                        ptw_active_o,
    output logic                        walking_instr_o,
    output logic                        itlb_miss_o,
    output logic                        dtlb_miss_o
);
    import ptw_pte_pkg::*;

    tlb_miss_t    miss;
    logic         busy;
    pte_t         pte;
    ptw_lvl_e     lvl;
    logic         is_instr;
    pte_verdict_e verdict;

    assign ptw_active_o = busy;

    ptw_miss_arbiter i_arbiter (
        .itlb_access_i          ( itlb_access_i          ),
        .itlb_hit_i             ( itlb_hit_i             ),
        .itlb_vaddr_i           ( itlb_vaddr_i           ),
        .dtlb_access_i          ( dtlb_access_i          ),
        .dtlb_hit_i             ( dtlb_hit_i             ),
        .dtlb_vaddr_i           ( dtlb_vaddr_i           ),
        .enable_translation_i   ( enable_translation_i   ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .busy_i                 ( busy                   ),
        .miss_o                 ( miss                   ),
        .itlb_miss_o            ( itlb_miss_o            ),
        .dtlb_miss_o            ( dtlb_miss_o            )
    );

    ptw_walk_fsm i_walk_fsm (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .miss_i          ( miss            ),
        .busy_o          ( busy            ),
        .satp_ppn_i      ( satp_ppn_i      ),
        .asid_i          ( asid_i          ),
        .mem_req_o       ( mem_req_o       ),
        .mem_rsp_i       ( mem_rsp_i       ),
        .pte_o           ( pte             ),
        .lvl_o           ( lvl             ),
        .is_instr_o      ( is_instr        ),
        .verdict_i       ( verdict         ),
        .itlb_update_o   ( itlb_update_o   ),
        .dtlb_update_o   ( dtlb_update_o   ),
        .ptw_error_o     ( ptw_error_o     ),
        .walking_instr_o ( walking_instr_o )
    );

    ptw_pte_checker i_pte_checker (
        .pte_i      ( pte            ),
        .lvl_i      ( lvl            ),
        .is_instr_i ( is_instr       ),
        .is_store_i ( lsu_is_store_i ),
        .mxr_i      ( mxr_i          ),
        .verdict_o  ( verdict        )
    );

endmodule

// ==== tests/ptw_chk.sv ====
/* Concurrent checks on the walker memory port and its result outputs.
   Bound into ptw_top from the testbench. */

`timescale 1ns/1ps

module ptw_chk (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  ptw_mem_pkg::ptw_mem_req_t   mem_req_i,
    input  ptw_mem_pkg::ptw_mem_rsp_t   mem_rsp_i,
    input  ptw_pte_pkg::tlb_update_t    itlb_update_i,
    input  ptw_pte_pkg::tlb_update_t    dtlb_update_i,
    input  logic                        ptw_error_i,
    input  logic                        ptw_active_i
);

    // request held with the same address until a grant
    req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.valid && !mem_rsp_i.gnt |=> mem_req_i.valid && $stable(mem_req_i.addr))
        else $error("memory request dropped or changed before its grant");

    // a walk ends in either an update or a page fault
    result_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !((itlb_update_i.valid || dtlb_update_i.valid) && ptw_error_i))
        else $error("TLB update and page fault in the same cycle");

    // memory is only read during a walk
    req_active_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_i.valid |-> ptw_active_i)
        else $error("memory request while the walker is idle");

endmodule

// ==== tests/ptw_tb.sv ====
/* Testbench for the Sv39 page-table walker. Replays a table of page-table rows
   through both TLB ports, with a memory model that grants and answers late. */

`timescale 1ns/1ps

`include "ptw_consts.svh"

module ptw_tb;
    import ptw_mem_pkg::*;
    import ptw_pte_pkg::*;

    localparam int unsigned timeout_cycles = 200;
    localparam int unsigned nrows          = 12;

    // PTE flag bits
    localparam logic [7:0] flag_v = 8'h01;
    localparam logic [7:0] flag_r = 8'h02;
    localparam logic [7:0] flag_w = 8'h04;
    localparam logic [7:0] flag_x = 8'h08;
    localparam logic [7:0] flag_g = 8'h20;
    localparam logic [7:0] flag_a = 8'h40;
    localparam logic [7:0] flag_d = 8'h80;

    // one walk where pte[k] answers the read at level k+1
    typedef struct packed {
        logic                  is_instr;
        logic                  is_store;
        logic                  mxr;
        logic [`PTW_VLEN-1:0]  vaddr;
        logic [2:0][63:0]      pte;
        logic                  exp_error;
        logic [1:0]            exp_lvl;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  itlb_access, itlb_hit, dtlb_access, dtlb_hit;
    logic [`PTW_VLEN-1:0]  itlb_vaddr, dtlb_vaddr;
    logic                  en_translation, en_ld_st;
    logic [`PTW_PPNW-1:0]  satp_ppn;
    logic [`PTW_ASIDW-1:0] asid;
    logic                  mxr, is_store;
    ptw_mem_req_t          mem_req;
    ptw_mem_rsp_t          mem_rsp;
    tlb_update_t           itlb_update, dtlb_update;
    logic                  ptw_error, ptw_active, walking_instr;
    logic                  itlb_miss, dtlb_miss;

    integer seed;
    row_t   rows [nrows];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ptw_top UUT (
        .clk_i                  ( clk            ),
        .rst_ni                 ( rst_n          ),
        .itlb_access_i          ( itlb_access    ),
        .itlb_hit_i             ( itlb_hit       ),
        .itlb_vaddr_i           ( itlb_vaddr     ),
        .dtlb_access_i          ( dtlb_access    ),
        .dtlb_hit_i             ( dtlb_hit       ),
        .dtlb_vaddr_i           ( dtlb_vaddr     ),
        .enable_translation_i   ( en_translation ),
        .en_ld_st_translation_i ( en_ld_st       ),
        .satp_ppn_i             ( satp_ppn       ),
        .asid_i                 ( asid           ),
        .mxr_i                  ( mxr            ),
        .lsu_is_store_i         ( is_store       ),
        .mem_req_o              ( mem_req        ),
        .mem_rsp_i              ( mem_rsp        ),
        .itlb_update_o          ( itlb_update    ),
        .dtlb_update_o          ( dtlb_update    ),
        .ptw_error_o            ( ptw_error      ),
        .ptw_active_o           ( ptw_active     ),
        .walking_instr_o        ( walking_instr  ),
        .itlb_miss_o            ( itlb_miss      ),
        .dtlb_miss_o            ( dtlb_miss      )
    );

    bind ptw_top ptw_chk i_chk (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .mem_req_i     ( mem_req_o     ),
        .mem_rsp_i     ( mem_rsp_i     ),
        .itlb_update_i ( itlb_update_o ),
        .dtlb_update_i ( dtlb_update_o ),
        .ptw_error_i   ( ptw_error_o   ),
        .ptw_active_i  ( ptw_active_o  )
    );

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            stop_on_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    function automatic logic [63:0] make_pte(input logic [`PTW_PPNW-1:0] ppn,
                                             input logic [7:0] flags);
        return {10'b0, ppn, 2'b00, flags};
    endfunction

    // table base times the page size plus index times the PTE size
    function automatic logic [`PTW_PLEN-1:0] pte_addr(input logic [`PTW_PPNW-1:0] base,
                                                      input logic [`PTW_VPNW-1:0] index);
        logic [`PTW_PLEN-1:0] page;
        logic [`PTW_PLEN-1:0] offset;
        page   = base;
        offset = index;
        return page * 4096 + offset * 8;
    endfunction

    task automatic set_row(input int idx, input logic is_instr, input logic st,
                           input logic mx, input logic [`PTW_VLEN-1:0] va,
                           input logic [63:0] p0, input logic [63:0] p1,
                           input logic [63:0] p2, input logic err, input logic [1:0] lvl);
        rows[idx].is_instr  = is_instr;
        rows[idx].is_store  = st;
        rows[idx].mxr       = mx;
        rows[idx].vaddr     = va;
        rows[idx].pte       = {p2, p1, p0};
        rows[idx].exp_error = err;
        rows[idx].exp_lvl   = lvl;
    endtask

    task automatic load_table();
        logic [63:0] ptr1;
        logic [63:0] ptr2;
        ptr1 = make_pte(44'h8_0100, flag_v);
        ptr2 = make_pte(44'h8_0200, flag_v);
        // 4K load with the global bit only on the middle pointer
        set_row(0, 0, 0, 0, 39'h2a_5a5c_3123, ptr1, make_pte(44'h8_0300, flag_v | flag_g),
                make_pte(44'h9_abcd, flag_v | flag_r | flag_w | flag_a | flag_d), 0, 3);
        set_row(1, 1, 0, 0, 39'h45_1234_5678,
                make_pte(44'hc_0000, flag_v | flag_x | flag_a | flag_g), 0, 0, 0, 1);
        set_row(2, 1, 0, 0, 39'h11_c0de_1000, ptr1,
                make_pte(44'h1_2200, flag_v | flag_r | flag_x | flag_a), 0, 0, 2);
        // ---------------------------------------------
        // page faults
        // ---------------------------------------------
        set_row(3, 0, 0, 0, 39'h03_0040_2000, make_pte(44'h8_0400, flag_r | flag_a), 0, 0,
                1, 1);
        set_row(4, 0, 0, 0, 39'h07_1ff0_3008, ptr1,
                make_pte(44'h8_0600, flag_v | flag_w | flag_a), 0, 1, 2);
        set_row(5, 0, 1, 0, 39'h5b_2468_a010, ptr1, ptr2,
                make_pte(44'h9_0001, flag_v | flag_r | flag_w | flag_a), 1, 3);
        set_row(6, 1, 0, 0, 39'h62_8642_0ff8, ptr2, ptr1,
                make_pte(44'h9_0002, flag_v | flag_r | flag_a | flag_d), 1, 3);
        set_row(7, 0, 0, 0, 39'h4a_0000_0100,
                make_pte(44'hc_0001, flag_v | flag_r | flag_a), 0, 0, 1, 1);
        set_row(8, 0, 0, 0, 39'h19_3579_b000, ptr1, ptr2, make_pte(44'h8_0700, flag_v), 1, 3);
        // execute-only page that is readable only with mxr
        set_row(9, 0, 0, 1, 39'h2c_a5a5_5000, ptr2, ptr1,
                make_pte(44'h9_0003, flag_v | flag_x | flag_a), 0, 3);
        set_row(10, 0, 0, 0, 39'h2c_a5a5_5000, ptr2, ptr1,
                make_pte(44'h9_0003, flag_v | flag_x | flag_a), 1, 3);
        set_row(11, 0, 1, 0, 39'h33_4400_7ff0, ptr2,
                make_pte(44'h2_4400, flag_v | flag_r | flag_w | flag_a | flag_d), 0, 0, 2);
    endtask

    task automatic start_miss(input row_t r);
        if (r.is_instr) begin
            itlb_access = 1'b1;
            itlb_vaddr  = r.vaddr;
        end else begin
            dtlb_access = 1'b1;
            dtlb_vaddr  = r.vaddr;
        end
        is_store = r.is_store;
        mxr      = r.mxr;
    endtask

    // sample a little after the falling edge since the pulse is combinational
    task automatic wait_miss_pulse(input logic is_instr);
        int unsigned cycles;
        cycles = 0;
        #1;
        while (!(is_instr ? itlb_miss : dtlb_miss)) begin
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_on_failure("the arbiter never pulsed the expected miss output");
            end
            @(negedge clk);
            #1;
        end
        if (is_instr) begin
            check_value("dtlb_miss_o", dtlb_miss, 0);
        end else begin
            check_value("itlb_miss_o", itlb_miss, 0);
        end
    endtask

    // memory model for one PTE read entered at the edge where the request is seen
    task automatic serve_request(input row_t r, input int unsigned k);
        logic [`PTW_PPNW-1:0] base;
        int unsigned          delay;
        if (k == 0) begin
            base = satp_ppn;
        end else begin
            base = r.pte[k-1][53:10];
        end
        check_value($sformatf("mem_req_o.addr of read %0d", k), mem_req.addr,
                    pte_addr(base, r.vaddr[`PTW_PGOFF + (2-k)*`PTW_VPNW +: `PTW_VPNW]));
        delay = {$random(seed)} % 4;
        repeat (delay) @(negedge clk);
        mem_rsp.gnt = 1'b1;
        @(negedge clk);
        mem_rsp.gnt = 1'b0;
        // answer one to three cycles after the grant
        delay = {$random(seed)} % 3;
        repeat (delay) @(negedge clk);
        mem_rsp.rvalid = 1'b1;
        mem_rsp.rdata  = r.pte[k];
    endtask

    task automatic serve_walk(input row_t r);
        int unsigned           cycles;
        int unsigned           reads;
        logic                  got_update;
        logic                  got_error;
        logic                  any_g;
        logic [`PTW_ASIDW-1:0] exp_asid;
        tlb_update_t           upd;
        pte_t                  exp_pte;
        string                 side;
        cycles     = 0;
        reads      = 0;
        got_update = 1'b0;
        got_error  = 1'b0;
        exp_asid   = asid;
        side       = r.is_instr ? "itlb_update_o" : "dtlb_update_o";
        while (!got_update && !got_error) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_on_failure("the walk ended in neither an update nor a page fault");
            end
            // the walk must keep the ASID it saw with the miss
            if (cycles == 1) begin
                asid = ~exp_asid;
            end
            check_value("ptw_active_o", ptw_active, 1);
            check_value("walking_instr_o", walking_instr, r.is_instr);
            check_value("itlb_miss_o", itlb_miss, 0);
            check_value("dtlb_miss_o", dtlb_miss, 0);
            got_update = r.is_instr ? itlb_update.valid : dtlb_update.valid;
            got_error  = ptw_error;
            upd        = r.is_instr ? itlb_update : dtlb_update;
            if (r.is_instr) begin
                check_value("dtlb_update_o.valid", dtlb_update.valid, 0);
            end else begin
                check_value("itlb_update_o.valid", itlb_update.valid, 0);
            end
            mem_rsp.rvalid = 1'b0;
            if (mem_req.valid) begin
                assert (reads < 3) else begin
                    stop_on_failure("the walker read more PTEs than Sv39 has levels");
                end
                serve_request(r, reads);
                reads++;
            end
        end
        asid = exp_asid;
        check_value("ptw_error_o", got_error, r.exp_error);
        check_value("number of PTE reads", reads, r.exp_lvl);
        if (!r.exp_error) begin
            any_g = 1'b0;
            for (int i = 0; i < r.exp_lvl; i++) begin
                any_g |= |(r.pte[i][7:0] & flag_g);
            end
            exp_pte   = r.pte[r.exp_lvl-1];
            exp_pte.g = any_g;
            check_value({side, ".content"}, upd.content, exp_pte);
            check_value({side, ".vpn"}, upd.vpn, r.vaddr[`PTW_VLEN-1:`PTW_PGOFF]);
            check_value({side, ".asid"}, upd.asid, exp_asid);
            check_value({side, ".is_1g"}, upd.is_1g, r.exp_lvl == 1);
            check_value({side, ".is_2m"}, upd.is_2m, r.exp_lvl == 2);
        end
        // drop the miss so the walker does not start again
        if (r.is_instr) begin
            itlb_access = 1'b0;
        end else begin
            dtlb_access = 1'b0;
        end
    endtask

    // the result is a single pulse and the walker is idle after it
    task automatic check_idle();
        @(negedge clk);
        check_value("ptw_error_o", ptw_error, 0);
        check_value("itlb_update_o.valid", itlb_update.valid, 0);
        check_value("dtlb_update_o.valid", dtlb_update.valid, 0);
        check_value("ptw_active_o", ptw_active, 0);
    endtask

    // a TLB hit or a side with translation off never starts a walk
    task automatic check_filtered_access();
        itlb_access = 1'b1;
        itlb_hit    = 1'b1;
        dtlb_access = 1'b1;
        dtlb_hit    = 1'b1;
        #1;
        check_value("itlb_miss_o", itlb_miss, 0);
        check_value("dtlb_miss_o", dtlb_miss, 0);
        @(negedge clk);
        check_value("ptw_active_o", ptw_active, 0);
        itlb_hit       = 1'b0;
        dtlb_hit       = 1'b0;
        en_translation = 1'b0;
        en_ld_st       = 1'b0;
        #1;
        check_value("itlb_miss_o", itlb_miss, 0);
        check_value("dtlb_miss_o", dtlb_miss, 0);
        @(negedge clk);
        check_value("ptw_active_o", ptw_active, 0);
        itlb_access    = 1'b0;
        dtlb_access    = 1'b0;
        en_translation = 1'b1;
        en_ld_st       = 1'b1;
    endtask

    initial begin
        rst_n          = 1'b0;
        itlb_access    = 1'b0;
        itlb_hit       = 1'b0;
        itlb_vaddr     = '0;
        dtlb_access    = 1'b0;
        dtlb_hit       = 1'b0;
        dtlb_vaddr     = '0;
        en_translation = 1'b1;
        en_ld_st       = 1'b1;
        satp_ppn       = 44'h000_0008_0001;
        asid           = 16'h5a3c;
        mxr            = 1'b0;
        is_store       = 1'b0;
        mem_rsp        = '0;
        seed           = 32'h9e0d_2ead;
        load_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // whole table twice with different random delays in each pass
        for (int p = 0; p < 2; p++) begin
            asid = (p == 0) ? 16'h5a3c : 16'hc3a5;
            for (int i = 0; i < nrows; i++) begin
                start_miss(rows[i]);
                wait_miss_pulse(rows[i].is_instr);
                serve_walk(rows[i]);
                check_idle();
            end
        end

        // both TLBs miss together and the data side goes first
        start_miss(rows[2]);
        start_miss(rows[0]);
        wait_miss_pulse(1'b0);
        serve_walk(rows[0]);
        check_idle();
        wait_miss_pulse(1'b1);
        serve_walk(rows[2]);
        check_idle();

        check_filtered_access();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/ptw_mem_pkg.sv
verilog/ptw_pte_pkg.sv
verilog/ptw_miss_arbiter.sv
verilog/ptw_pte_checker.sv
verilog/ptw_walk_fsm.sv
verilog/ptw_top.sv
tests/ptw_chk.sv
tests/ptw_tb.sv

// ==== Bender.yml ====
package:
  name: ptw

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/ptw_mem_pkg.sv
      - verilog/ptw_pte_pkg.sv
      - verilog/ptw_miss_arbiter.sv
      - verilog/ptw_pte_checker.sv
      - verilog/ptw_walk_fsm.sv
      - verilog/ptw_top.sv
  - target: test
    files:
      - tests/ptw_chk.sv
      - tests/ptw_tb.sv
